/* rtl/post_norm_pkg.sv */
package post_norm_pkg;

	// ------------------------------
	// Single precision format
	// ------------------------------
	localparam int FRACT_W = 48;
	localparam int MANT_W = 23;
	localparam int HIDDEN_POS = 46;
	localparam int EXP_MAX = 255;
	localparam int EXP_LARGEST = 254;

	typedef logic [7:0] exp_t;
	typedef logic [FRACT_W-1:0] fract_in_t;
	typedef logic [MANT_W-1:0] mant_t;
	typedef logic [5:0] lz_t;
	typedef logic [1:0] rmode_t;

	localparam rmode_t RM_NEAREST = 2'd0;
	localparam rmode_t RM_ZERO = 2'd1;
	localparam rmode_t RM_UP = 2'd2;
	localparam rmode_t RM_DOWN = 2'd3;

	// ------------------------------
	// Register map, word addresses
	// ------------------------------
	localparam int ADR_W = 3;

	localparam logic [ADR_W-1:0] REG_FRACT_HI = 3'd0;
	localparam logic [ADR_W-1:0] REG_FRACT_LO = 3'd1;
	localparam logic [ADR_W-1:0] REG_CTRL = 3'd2;
	localparam logic [ADR_W-1:0] REG_RESULT = 3'd3;
	localparam logic [ADR_W-1:0] REG_STATUS = 3'd4;

	// ------------------------------
	// Bus request and stage payloads
	// ------------------------------
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [ADR_W-1:0] adr;
		logic [31:0] wdata;
	} wb_req_t;

	typedef struct packed {
		logic sign;
		rmode_t rmode;
		exp_t exponent;
		fract_in_t fract;
	} operand_t;

	// Exponent carries one extra bit so overflow stays visible
	typedef struct packed {
		logic sign;
		rmode_t rmode;
		logic [8:0] exponent;
		fract_in_t fract;
		logic sticky;
	} norm_t;

	typedef struct packed {
		logic sign;
		rmode_t rmode;
		logic [8:0] exponent;
		logic hidden;
		mant_t mant;
		logic inexact;
	} rounded_t;

	typedef struct packed {
		logic [31:0] word;
		logic inexact;
		logic overflow;
		logic underflow;
	} result_t;

endpackage

/* rtl/lead_zero_count.sv */
`timescale 1ns/1ns

module lead_zero_count (
	input post_norm_pkg::fract_in_t fract,
	output post_norm_pkg::lz_t lz
);

	// Count is 1 for a leading one at bit 47, 48 for bit 0 or no one at all
	always_comb
	begin
		lz = post_norm_pkg::lz_t'(post_norm_pkg::FRACT_W);
		// Scan upward so the highest set bit decides
		for (int i = 0; i < post_norm_pkg::FRACT_W; i++)
		begin
			if (fract[i])
				lz = post_norm_pkg::lz_t'(post_norm_pkg::FRACT_W - i);
		end
	end

	lz_range: assert final (lz <= post_norm_pkg::lz_t'(post_norm_pkg::FRACT_W))
		else $error("lead_zero_count: count %0d out of range", lz);

endmodule

/* rtl/wb_slave_port.sv */
`timescale 1ns/1ns

module wb_slave_port (
	input logic clk,
	input logic reset,
	input post_norm_pkg::wb_req_t req,
	input post_norm_pkg::result_t result,
	input logic done,
	output logic [31:0] rdata,
	output logic ack,
	output logic launch,
	output post_norm_pkg::operand_t operand
);

	logic access;
	logic write;

	// New cycle seen while ack is low
	assign access = req.cyc & req.stb & ~ack;
	assign write = access & req.we;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			ack <= 1'b0;
			launch <= 1'b0;
		end
		else
		begin
			ack <= access;
			launch <= write && (req.adr == post_norm_pkg::REG_CTRL);
		end
	end

	// ------------------------------
	// Operand fields
	// ------------------------------
	// Written in place, stable while launch is high
	always_ff @(posedge clk)
	begin
		if (write)
		begin
			case (req.adr)
				post_norm_pkg::REG_FRACT_HI:
					operand.fract[47:32] <= req.wdata[15:0];
				post_norm_pkg::REG_FRACT_LO:
					operand.fract[31:0] <= req.wdata;
				post_norm_pkg::REG_CTRL:
				begin
					operand.exponent <= req.wdata[7:0];
					operand.sign <= req.wdata[8];
					operand.rmode <= req.wdata[10:9];
				end
				default: ;
			endcase
		end
	end

	// ------------------------------
	// Read mux
	// ------------------------------
	always_comb
	begin
		rdata = '0;
		case (req.adr)
			post_norm_pkg::REG_FRACT_HI:
				rdata[15:0] = operand.fract[47:32];
			post_norm_pkg::REG_FRACT_LO:
				rdata = operand.fract[31:0];
			post_norm_pkg::REG_CTRL:
				rdata[10:0] = {operand.rmode, operand.sign, operand.exponent};
			post_norm_pkg::REG_RESULT:
				rdata = result.word;
			post_norm_pkg::REG_STATUS:
				rdata[3:0] = {result.underflow, result.overflow, result.inexact, done};
			default:
				rdata = '0;
		endcase
	end

	ack_single: assert property (@(posedge clk) disable iff (reset) ack |=> !ack)
		else $error("wb_slave_port: ack held for two cycles");

endmodule

/* rtl/fract_normalize.sv */
`timescale 1ns/1ns

module fract_normalize (
	input logic clk,
	input logic reset,
	input logic launch,
	input post_norm_pkg::operand_t operand,
	output post_norm_pkg::norm_t norm,
	output logic norm_valid
);

	post_norm_pkg::lz_t lz;
	logic fract_zero;
	logic carry;
	logic [8:0] exp_eff;
	logic [8:0] shift_limit;
	logic [5:0] shift_req;
	logic full_shift;
	logic [5:0] shift_amt;
	post_norm_pkg::norm_t norm_next;

	lead_zero_count u_lzc (
		.fract(operand.fract),
		.lz(lz)
	);

	assign fract_zero = (operand.fract == '0);
	assign carry = operand.fract[post_norm_pkg::HIDDEN_POS + 1];

	// Zero exponent behaves as 1 for denormal inputs
	assign exp_eff = (operand.exponent == '0) ? 9'd1 : {1'b0, operand.exponent};

	// ------------------------------
	// Shift amount
	// ------------------------------
	// Distance from the leading one up to the hidden position
	assign shift_req = lz - post_norm_pkg::lz_t'(post_norm_pkg::FRACT_W -
		post_norm_pkg::HIDDEN_POS);

	// Cannot shift below exponent 1
	assign shift_limit = exp_eff - 9'd1;
	assign full_shift = ({3'b0, shift_req} <= shift_limit);
	assign shift_amt = full_shift ? shift_req : shift_limit[5:0];

	always_comb
	begin
		norm_next.sign = operand.sign;
		norm_next.rmode = operand.rmode;
		norm_next.sticky = 1'b0;
		if (carry)
		begin
			norm_next.fract = operand.fract >> 1;
			norm_next.sticky = operand.fract[0];
			norm_next.exponent = exp_eff + 9'd1;
		end
		else
		begin
			norm_next.fract = operand.fract << shift_amt;
			// Limited shift leaves a denormal
			if (fract_zero || !full_shift)
				norm_next.exponent = '0;
			else
				norm_next.exponent = exp_eff - {3'b0, shift_amt};
		end
	end

	// ------------------------------
	// Stage register
	// ------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
			norm_valid <= 1'b0;
		else
			norm_valid <= launch;
	end

	always_ff @(posedge clk)
	begin
		if (launch)
			norm <= norm_next;
	end

endmodule

/* rtl/round_unit.sv */
`timescale 1ns/1ns

module round_unit (
	input logic clk,
	input logic reset,
	input post_norm_pkg::norm_t norm,
	input logic norm_valid,
	output post_norm_pkg::rounded_t rnd,
	output logic rnd_valid
);

	localparam int GUARD_POS = post_norm_pkg::HIDDEN_POS - post_norm_pkg::MANT_W;

	logic guard_bit;
	logic round_bit;
	logic sticky_bit;
	logic incr;
	logic [24:0] sig_sum;
	post_norm_pkg::rounded_t rnd_next;

	assign guard_bit = norm.fract[GUARD_POS];
	assign round_bit = norm.fract[GUARD_POS - 1];
	assign sticky_bit = (|norm.fract[GUARD_POS-2:0]) | norm.sticky;

	// ------------------------------
	// Increment decision per mode
	// ------------------------------
	always_comb
	begin
		case (norm.rmode)
			post_norm_pkg::RM_NEAREST:
				incr = round_bit & (guard_bit | sticky_bit);
			post_norm_pkg::RM_UP:
				incr = (round_bit | sticky_bit) & ~norm.sign;
			post_norm_pkg::RM_DOWN:
				incr = (round_bit | sticky_bit) & norm.sign;
			default:
				incr = 1'b0;
		endcase
	end

	// Hidden bit plus mantissa, with carry out on top
	assign sig_sum = {1'b0, norm.fract[post_norm_pkg::HIDDEN_POS -: 24]} + {24'b0, incr};

	always_comb
	begin
		rnd_next.sign = norm.sign;
		rnd_next.rmode = norm.rmode;
		rnd_next.hidden = sig_sum[24] | sig_sum[23];
		rnd_next.mant = sig_sum[22:0];
		rnd_next.inexact = round_bit | sticky_bit;
		if (sig_sum[24])
			rnd_next.exponent = norm.exponent + 9'd1;
		else if (norm.exponent == '0 && sig_sum[23])
			rnd_next.exponent = 9'd1; // denormal rounded up into the normal range
		else
			rnd_next.exponent = norm.exponent;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			rnd_valid <= 1'b0;
		else
			rnd_valid <= norm_valid;
	end

	always_ff @(posedge clk)
	begin
		if (norm_valid)
			rnd <= rnd_next;
	end

	// Exact fractions leave mantissa and exponent untouched
	exact_passes: assert property (@(posedge clk) disable iff (reset)
		norm_valid && !(round_bit || sticky_bit) |=>
		rnd.mant == $past(norm.fract[post_norm_pkg::HIDDEN_POS-1 -: post_norm_pkg::MANT_W]) &&
		rnd.exponent == $past(norm.exponent))
		else $error("round_unit: exact fraction was incremented");

endmodule

/* rtl/result_pack.sv */
`timescale 1ns/1ns

module result_pack (
	input logic clk,
	input logic reset,
	input post_norm_pkg::rounded_t rnd,
	input logic rnd_valid,
	input logic launch,
	output post_norm_pkg::result_t result,
	output logic done
);

	logic ovf;
	logic to_inf;
	post_norm_pkg::exp_t exp_final;
	post_norm_pkg::mant_t mant_final;
	post_norm_pkg::result_t result_next;

	assign ovf = (rnd.exponent >= 9'(post_norm_pkg::EXP_MAX));

	// Modes that round away from the largest finite value
	assign to_inf = (rnd.rmode == post_norm_pkg::RM_NEAREST) ||
		(rnd.rmode == post_norm_pkg::RM_UP && !rnd.sign) ||
		(rnd.rmode == post_norm_pkg::RM_DOWN && rnd.sign);

	// ------------------------------
	// Saturation and flags
	// ------------------------------
	always_comb
	begin
		if (ovf)
		begin
			exp_final = to_inf ? post_norm_pkg::exp_t'(post_norm_pkg::EXP_MAX) :
				post_norm_pkg::exp_t'(post_norm_pkg::EXP_LARGEST);
			mant_final = to_inf ? '0 : '1;
		end
		else
		begin
			exp_final = rnd.exponent[7:0];
			mant_final = rnd.mant;
		end
		result_next.word = {rnd.sign, exp_final, mant_final};
		result_next.inexact = rnd.inexact | ovf;
		result_next.overflow = ovf;
		// Hidden bit clear means the result stayed denormal
		result_next.underflow = ~rnd.hidden & rnd.inexact;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			result <= '0;
			done <= 1'b0;
		end
		else
		begin
			if (rnd_valid)
				result <= result_next;
			// Launch wins, done then refers to the newest operation
			if (launch)
				done <= 1'b0;
			else if (rnd_valid)
				done <= 1'b1;
		end
	end

endmodule

/* rtl/post_norm_top.sv */
`timescale 1ns/1ns

module post_norm_top (
	input logic clk,
	input logic reset,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic [post_norm_pkg::ADR_W-1:0] wb_adr,
	input logic [31:0] wb_wdata,
	output logic [31:0] wb_rdata,
	output logic wb_ack
);

	post_norm_pkg::wb_req_t wb_req;
	post_norm_pkg::operand_t operand;
	post_norm_pkg::norm_t norm;
	post_norm_pkg::rounded_t rnd;
	post_norm_pkg::result_t result;
	logic launch;
	logic norm_valid;
	logic rnd_valid;
	logic done;

	assign wb_req = '{cyc: wb_cyc, stb: wb_stb, we: wb_we, adr: wb_adr, wdata: wb_wdata};

	wb_slave_port u_port (
		.clk(clk),
		.reset(reset),
		.req(wb_req),
		.result(result),
		.done(done),
		.rdata(wb_rdata),
		.ack(wb_ack),
		.launch(launch),
		.operand(operand)
	);

	// Three stage pipeline
	fract_normalize u_norm (
		.clk(clk),
		.reset(reset),
		.launch(launch),
		.operand(operand),
		.norm(norm),
		.norm_valid(norm_valid)
	);

	round_unit u_round (
		.clk(clk),
		.reset(reset),
		.norm(norm),
		.norm_valid(norm_valid),
		.rnd(rnd),
		.rnd_valid(rnd_valid)
	);

	result_pack u_pack (
		.clk(clk),
		.reset(reset),
		.rnd(rnd),
		.rnd_valid(rnd_valid),
		.launch(launch),
		.result(result),
		.done(done)
	);

endmodule

/* include/post_norm_model.svh */
`ifndef POST_NORM_MODEL_SVH
`define POST_NORM_MODEL_SVH

// Galois LFSR, taps 32 30 26 25
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
	lfsr_next = state[0] ? ((state >> 1) ^ 32'hA300_0000) : (state >> 1);
endfunction

// Reference post normalization and rounding
function automatic post_norm_pkg::result_t post_norm_model(
	input logic sign,
	input post_norm_pkg::rmode_t rmode,
	input post_norm_pkg::exp_t exp_in,
	input post_norm_pkg::fract_in_t fract
);
	post_norm_pkg::result_t res;
	logic [47:0] f;
	logic [24:0] sig;
	logic sticky;
	logic rbit;
	logic inc;
	logic to_inf;
	int p;
	int ee;
	int e;
	int sh;
	int i;
	res = '0;
	res.word = {sign, 31'b0};
	if (fract == '0)
		return res;
	p = 0;
	for (i = 0; i < 48; i++)
	begin
		if (fract[i])
			p = i;
	end
	ee = (exp_in == 0) ? 1 : int'(exp_in);
	f = fract;
	sticky = 1'b0;
	if (p == 47)
	begin
		sticky = f[0];
		f = f >> 1;
		e = ee + 1;
	end
	else
	begin
		sh = (46 - p < ee - 1) ? 46 - p : ee - 1;
		f = f << sh;
		e = (sh == 46 - p) ? ee - sh : 0;
	end
	rbit = f[22];
	sticky = sticky | (|f[21:0]);
	case (rmode)
		post_norm_pkg::RM_NEAREST: inc = rbit & (f[23] | sticky);
		post_norm_pkg::RM_UP: inc = (rbit | sticky) & ~sign;
		post_norm_pkg::RM_DOWN: inc = (rbit | sticky) & sign;
		default: inc = 1'b0;
	endcase
	sig = {1'b0, f[46:23]} + {24'b0, inc};
	if (sig[24])
		e = e + 1;
	else if (e == 0 && sig[23])
		e = 1;
	res.inexact = rbit | sticky;
	if (e >= 255)
	begin
		to_inf = (rmode == post_norm_pkg::RM_NEAREST) ||
			(rmode == post_norm_pkg::RM_UP && !sign) || (rmode == post_norm_pkg::RM_DOWN && sign);
		res.overflow = 1'b1;
		res.inexact = 1'b1;
		e = to_inf ? 255 : 254;
		sig[22:0] = to_inf ? 23'h0 : 23'h7fffff;
	end
	res.underflow = (e == 0) && res.inexact;
	res.word = {sign, 8'(e), sig[22:0]};
	return res;
endfunction

`endif

/* tests/tb_post_norm.sv */
`timescale 1ns/1ns

module tb_post_norm;

	localparam int CYCLE_LIMIT = 4000;
	localparam int ACK_WAIT = 4;

	logic clk;
	logic reset;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [post_norm_pkg::ADR_W-1:0] wb_adr;
	logic [31:0] wb_wdata;
	logic [31:0] wb_rdata;
	logic wb_ack;

	logic [31:0] rng_state = 32'he603;
	int cycle_count = 0;

	`include "post_norm_model.svh"

	post_norm_top UUT (
		.clk(clk),
		.reset(reset),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_wdata(wb_wdata),
		.wb_rdata(wb_rdata),
		.wb_ack(wb_ack)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic value_error(input string msg);
		$display("Error at %0t ns: %s", $time, msg);
		$display("Done: errors found");
		$fatal(1);
	endtask

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Done: errors found");
		$fatal(1);
	endtask

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT)
			abort_run("Simulation ran past its cycle limit without finishing");
	end

	// ------------------------------
	// Bus protocol checks
	// ------------------------------
	ack_after_strobe: assert property (@(posedge clk) disable iff (reset)
		wb_cyc && wb_stb && !wb_ack |=> wb_ack)
		else value_error("ack did not follow the strobe by one cycle");

	ack_one_cycle: assert property (@(posedge clk) disable iff (reset)
		wb_ack |=> !wb_ack)
		else value_error("ack stayed high for two cycles");

	// ------------------------------
	// Bus tasks
	// ------------------------------
	// All tasks start and end 2 ns after a rising edge
	task automatic wait_ack;
		int waited;
		waited = 0;
		@(negedge clk);
		while (!wb_ack)
		begin
			waited++;
			if (waited > ACK_WAIT)
				abort_run("Bus cycle was never acknowledged");
			@(negedge clk);
		end
	endtask

	task automatic end_cycle;
		@(posedge clk);
		#2;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	task automatic write_reg(input logic [post_norm_pkg::ADR_W-1:0] adr, input logic [31:0] data);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = 1'b1;
		wb_adr = adr;
		wb_wdata = data;
		wait_ack();
		end_cycle();
	endtask

	task automatic read_reg(input logic [post_norm_pkg::ADR_W-1:0] adr, output logic [31:0] data);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = 1'b0;
		wb_adr = adr;
		wait_ack();
		data = wb_rdata;
		end_cycle();
	endtask

	task automatic idle_cycle;
		@(posedge clk);
		#2;
	endtask

	function automatic logic [31:0] ctrl_word(input logic sign, input post_norm_pkg::rmode_t rmode,
		input post_norm_pkg::exp_t exp_in);
		return {21'b0, rmode, sign, exp_in};
	endfunction

	function automatic logic [47:0] draw_bits(input int n);
		logic [47:0] v;
		int k;
		v = '0;
		for (k = 0; k < n; k++)
		begin
			rng_state = lfsr_next(rng_state);
			v = {v[46:0], rng_state[0]};
		end
		return v;
	endfunction

	task automatic check_result(input post_norm_pkg::result_t got,
		input post_norm_pkg::result_t expd, input string what);
		assert (got == expd)
			else value_error($sformatf("%s: got %h flags %b, expected %h flags %b",
				what, got.word, got[2:0], expd.word, expd[2:0]));
	endtask

	task automatic read_outcome(output post_norm_pkg::result_t got);
		logic [31:0] word;
		logic [31:0] status;
		read_reg(post_norm_pkg::REG_RESULT, word);
		read_reg(post_norm_pkg::REG_STATUS, status);
		assert (status[0])
			else value_error("done not set after the result landed");
		got = {word, status[1], status[2], status[3]};
	endtask

	task automatic run_operand(input logic sign, input post_norm_pkg::rmode_t rmode,
		input post_norm_pkg::exp_t exp_in, input post_norm_pkg::fract_in_t fract,
		output post_norm_pkg::result_t got);
		write_reg(post_norm_pkg::REG_FRACT_HI, {16'b0, fract[47:32]});
		write_reg(post_norm_pkg::REG_FRACT_LO, fract[31:0]);
		write_reg(post_norm_pkg::REG_CTRL, ctrl_word(sign, rmode, exp_in));
		// Result lands on the third edge after the CTRL ack
		idle_cycle();
		read_outcome(got);
		check_result(got, post_norm_model(sign, rmode, exp_in, fract), "single operand");
	endtask

	// Second launch while the first is still in the pipeline
	task automatic run_pair(input logic sign_a, input post_norm_pkg::rmode_t rmode_a,
		input post_norm_pkg::exp_t exp_a, input logic sign_b, input post_norm_pkg::rmode_t rmode_b,
		input post_norm_pkg::exp_t exp_b, input post_norm_pkg::fract_in_t fract);
		post_norm_pkg::result_t expd_a;
		post_norm_pkg::result_t got;
		logic [31:0] word_a;
		expd_a = post_norm_model(sign_a, rmode_a, exp_a, fract);
		write_reg(post_norm_pkg::REG_FRACT_HI, {16'b0, fract[47:32]});
		write_reg(post_norm_pkg::REG_FRACT_LO, fract[31:0]);
		write_reg(post_norm_pkg::REG_CTRL, ctrl_word(sign_a, rmode_a, exp_a));
		write_reg(post_norm_pkg::REG_CTRL, ctrl_word(sign_b, rmode_b, exp_b));
		read_reg(post_norm_pkg::REG_RESULT, word_a);
		assert (word_a == expd_a.word)
			else value_error($sformatf("first of pair: got %h, expected %h", word_a, expd_a.word));
		read_outcome(got);
		check_result(got, post_norm_model(sign_b, rmode_b, exp_b, fract), "second of pair");
	endtask

	// ------------------------------
	// Test sequence
	// ------------------------------
	initial
	begin
		post_norm_pkg::result_t got;
		post_norm_pkg::rmode_t rm;
		post_norm_pkg::exp_t exp_a;
		post_norm_pkg::exp_t exp_b;
		post_norm_pkg::fract_in_t fract;
		logic [31:0] data;
		logic sign_a;
		logic sign_b;
		logic inc;
		logic to_inf;
		int n;

		reset = 1'b1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_wdata = '0;
		repeat (10) @(posedge clk);
		#2;
		reset = 1'b0;

		// Carry and a long left shift
		run_operand(1'b0, post_norm_pkg::RM_NEAREST, 8'h80, 48'h8000_0000_0000, got);
		check_result(got, {32'h4080_0000, 3'b000}, "carry fraction");
		run_operand(1'b0, post_norm_pkg::RM_NEAREST, 8'h80, 48'h0000_4000_0000, got);
		check_result(got, {32'h3800_0000, 3'b000}, "leading one at bit 30");

		// Round bit and sticky set, guard clear
		for (int s = 0; s < 2; s++)
		begin
			for (int m = 0; m < 4; m++)
			begin
				rm = post_norm_pkg::rmode_t'(m);
				inc = (rm == post_norm_pkg::RM_NEAREST) ||
					(rm == post_norm_pkg::RM_UP && s == 0) ||
					(rm == post_norm_pkg::RM_DOWN && s == 1);
				run_operand(1'(s), rm, 8'h80, 48'h4000_0060_0000, got);
				check_result(got, {1'(s), 8'h80, 22'b0, inc, 3'b100}, "rounding mode");
			end
		end

		// Exponent 254 plus carry
		for (int s = 0; s < 2; s++)
		begin
			for (int m = 0; m < 4; m++)
			begin
				rm = post_norm_pkg::rmode_t'(m);
				to_inf = (rm == post_norm_pkg::RM_NEAREST) ||
					(rm == post_norm_pkg::RM_UP && s == 0) ||
					(rm == post_norm_pkg::RM_DOWN && s == 1);
				run_operand(1'(s), rm, 8'd254, 48'h8000_0000_0000, got);
				if (to_inf)
					check_result(got, {1'(s), 8'hff, 23'h0, 3'b110}, "overflow to infinity");
				else
					check_result(got, {1'(s), 8'hfe, 23'h7f_ffff, 3'b110}, "overflow to largest");
			end
		end

		// Denormal with limited shift, then signed zeros
		run_operand(1'b0, post_norm_pkg::RM_ZERO, 8'd3, 48'h0100_0010_0000, got);
		check_result(got, {32'h0008_0000, 3'b101}, "denormal");
		run_operand(1'b1, post_norm_pkg::RM_NEAREST, 8'h55, 48'h0, got);
		check_result(got, {32'h8000_0000, 3'b000}, "negative zero");
		run_operand(1'b0, post_norm_pkg::RM_UP, 8'h55, 48'h0, got);
		check_result(got, {32'h0000_0000, 3'b000}, "positive zero");

		// Register readback, done still low one edge before the result
		write_reg(post_norm_pkg::REG_FRACT_HI, 32'h0000_abcd);
		write_reg(post_norm_pkg::REG_FRACT_LO, 32'h1234_5678);
		write_reg(post_norm_pkg::REG_CTRL, ctrl_word(1'b1, post_norm_pkg::RM_UP, 8'h85));
		read_reg(post_norm_pkg::REG_STATUS, data);
		assert (data[0] == 1'b0)
			else value_error("done set before the third edge after launch");
		read_reg(post_norm_pkg::REG_FRACT_HI, data);
		assert (data == 32'h0000_abcd)
			else value_error($sformatf("FRACT_HI read %h", data));
		read_reg(post_norm_pkg::REG_FRACT_LO, data);
		assert (data == 32'h1234_5678)
			else value_error($sformatf("FRACT_LO read %h", data));
		read_reg(post_norm_pkg::REG_CTRL, data);
		assert (data == 32'h0000_0585)
			else value_error($sformatf("CTRL read %h", data));
		read_outcome(got);
		check_result(got, post_norm_model(1'b1, post_norm_pkg::RM_UP, 8'h85,
			48'habcd_1234_5678), "readback operand");

		// Same operand again, done read right on the third edge
		write_reg(post_norm_pkg::REG_CTRL, ctrl_word(1'b1, post_norm_pkg::RM_UP, 8'h85));
		idle_cycle();
		read_reg(post_norm_pkg::REG_STATUS, data);
		assert (data[0] == 1'b1)
			else value_error("done not set on the third edge after launch");

		// Random operands, every fifth one launched back to back
		n = 0;
		while (n < 200)
		begin
			sign_a = 1'(draw_bits(1));
			rm = post_norm_pkg::rmode_t'(draw_bits(2));
			exp_a = post_norm_pkg::exp_t'(draw_bits(8));
			if (draw_bits(2) == 48'd0)
				exp_a = {5'b0, exp_a[2:0]};
			fract = draw_bits(48) >> (draw_bits(6) % 50);
			if (n % 5 == 4)
			begin
				sign_b = 1'(draw_bits(1));
				exp_b = post_norm_pkg::exp_t'(draw_bits(8));
				run_pair(sign_a, rm, exp_a, sign_b, post_norm_pkg::rmode_t'(draw_bits(2)),
					exp_b, fract);
				n += 2;
			end
			else
			begin
				run_operand(sign_a, rm, exp_a, fract, got);
				n += 1;
			end
		end

		$display("Done: no errors");
		$finish;
	end

endmodule

/* compile.f */
+incdir+include
rtl/post_norm_pkg.sv
rtl/lead_zero_count.sv
rtl/wb_slave_port.sv
rtl/fract_normalize.sv
rtl/round_unit.sv
rtl/result_pack.sv
rtl/post_norm_top.sv
tests/tb_post_norm.sv
